// ==== bench/flashControllerTb.sv ====
`timescale 1ns/1ns
// Flash controller testbench
// Plays bus starts from the test file, follows the flash cycle timing edge by
// edge and compares strobes, acknowledge and flash address on every clock

module flashControllerTb;

    localparam logic [flashPkg::regionBits-1:0] flashRegionTb = 4'hF; // Window under test
    localparam int dropEdges   = 5;  // Next free start after an accepted one
    localparam int ackTimeout  = 20; // Cycles allowed for missing acks
    localparam int idleTimeout = 20; // Cycles allowed to go quiet

    logic                  CLK40;
    logic                  RESETn;
    logic                  tsN;
    logic                  rnW;
    flashPkg::busAddrT     addr;
    logic                  tack;
    flashPkg::flashOffsetT flashA;
    logic                  flashEnN;
    logic                  flashReadN;
    logic                  flashWriteN;
    logic                  flashRstN;

    int   edgeCnt        = 0;    // Rising edges so far
    int   lastAcc        = -100; // Sampling edge of last accepted start
    int   expAcks        = 0;
    int   ackCount       = 0;
    int   mismatchErrors = 0;
    int   timeoutErrors  = 0;
    int   otherErrors    = 0;
    logic checkOn        = 1'b0;
    logic prevTack       = 1'b0;

    // Accepted starts the edge counter has not reached yet
    int                    accEdgeQ[$];
    logic                  accWriteQ[$];
    flashPkg::flashOffsetT accOffQ[$];

    // Flash cycle being followed
    logic                  haveCycle = 1'b0;
    int                    curEdge   = 0;
    logic                  curWrite  = 1'b0;
    flashPkg::flashOffsetT curOff    = '0;

    flashController #(
        .flashRegion (flashRegionTb)
    ) u_flashController (
        .CLK40       (CLK40),
        .RESETn      (RESETn),
        .tsN         (tsN),
        .rnW         (rnW),
        .addr        (addr),
        .tack        (tack),
        .flashA      (flashA),
        .flashEnN    (flashEnN),
        .flashReadN  (flashReadN),
        .flashWriteN (flashWriteN),
        .flashRstN   (flashRstN)
    );

    initial begin
        CLK40 = 1'b0;
        forever #20 CLK40 = ~CLK40; // 40 ns period
    end

    always @(posedge CLK40) edgeCnt <= edgeCnt + 1;

    task automatic checkBit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            mismatchErrors++;
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkOffset(input string what, input flashPkg::flashOffsetT got,
                               input flashPkg::flashOffsetT exp);
        if (got !== exp) begin
            mismatchErrors++;
            $display("Mismatch at %0t ns: %s is %05h, expected %05h", $time, what, got, exp);
        end
    endtask

    task automatic checkCount(input string what, input int got, input int exp);
        if (got != exp) begin
            mismatchErrors++;
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Expected pins after the last rising edge, from the cycle timing
    task automatic compareOutputs();
        int   d;
        logic expTack;
        logic expEnN;
        logic expReadN;
        logic expWriteN;
        while (accEdgeQ.size() > 0 && accEdgeQ[0] <= edgeCnt) begin
            curEdge   = accEdgeQ.pop_front();
            curWrite  = accWriteQ.pop_front();
            curOff    = accOffQ.pop_front();
            haveCycle = 1'b1;
        end
        d         = edgeCnt - curEdge;                 // Edges since sampling
        expTack   = haveCycle && (d == 2);
        expEnN    = !(haveCycle && d >= 1 && d <= (curWrite ? 3 : 4));
        expReadN  = !(haveCycle && !curWrite && d >= 1 && d <= 4);
        expWriteN = !(haveCycle && curWrite && d >= 1 && d <= 2);
        checkBit("tack", tack, expTack);
        checkBit("flashEnN", flashEnN, expEnN);
        checkBit("flashReadN", flashReadN, expReadN);
        checkBit("flashWriteN", flashWriteN, expWriteN);
        if (haveCycle) begin
            checkOffset("flashA", flashA, curOff);     // Holds through drops
        end
        if (tack && !prevTack) begin
            ackCount++;
        end
        prevTack = tack;
    endtask

    always @(negedge CLK40) if (checkOn) compareOutputs();

    // Reset pin is combinational, RESETn settles long before the rising edge
    always @(posedge CLK40) if (checkOn) checkBit("flashRstN", flashRstN, RESETn);

    task automatic driveStart(input logic isRead, input logic [flashPkg::addrBits-1:0] addrVal);
        flashPkg::busAddrT a;
        int                e;
        @(negedge CLK40);
        a.raw = addrVal;
        tsN   = 1'b0;
        rnW   = isRead;
        addr  = a;
        e     = edgeCnt + 1;                             // Edge that samples it
        if (a.fields.regionSel == flashRegionTb && e - lastAcc >= dropEdges) begin
            lastAcc = e;
            accEdgeQ.push_back(e);
            accWriteQ.push_back(!isRead);
            accOffQ.push_back(a.fields.flashOffset);
            expAcks++;
        end
    endtask

    task automatic waitForAcks(input int target);
        int waited;
        waited = 0;
        while (ackCount < target && waited < ackTimeout) begin
            @(posedge CLK40);
            waited++;
        end
        if (ackCount < target) begin
            timeoutErrors++;
            $display("Timeout: only %0d of %0d transfer acknowledges arrived", ackCount, target);
        end
    endtask

    task automatic waitForIdle();
        int waited;
        waited = 0;
        while ((edgeCnt - lastAcc <= dropEdges || flashEnN !== 1'b1) && waited < idleTimeout) begin
            @(negedge CLK40);
            waited++;
        end
        if (flashEnN !== 1'b1) begin
            timeoutErrors++;
            $display("Timeout: flash enable never went inactive after the last cycle");
        end
    endtask

    initial begin
        int                            fd;
        int                            code;
        logic                          done;
        logic [7:0]                    opChar;
        logic [flashPkg::addrBits-1:0] addrVal;
        int                            gapVal;
        logic [8*160-1:0]              lineBuf;
        RESETn = 1'b0;
        tsN    = 1'b1;
        rnW    = 1'b1;
        addr   = '0;
        @(posedge CLK40);
        checkOn = 1'b1;                     // Outputs defined from here
        repeat (3) @(posedge CLK40);        // Four reset edges
        @(negedge CLK40);
        RESETn = 1'b1;
        repeat (2) @(negedge CLK40);
        fd = $fopen("bench/flashControllerTests.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("Cannot open the test file bench/flashControllerTests.txt");
            done = 1'b1;
        end else begin
            done = 1'b0;
        end
        while (!done) begin
            code = $fscanf(fd, " %c", opChar);
            if (code != 1) begin
                done = 1'b1;                // End of file
            end else if (opChar == "#") begin
                code = $fgets(lineBuf, fd); // Skip comment text
            end else begin
                code = $fscanf(fd, " %h %d", addrVal, gapVal);
                if (code != 2 || gapVal < 1) begin
                    otherErrors++;
                    $display("Malformed line in the test file, reading stopped");
                    done = 1'b1;
                end else if (opChar != "R" && opChar != "W") begin
                    otherErrors++;
                    $display("Unknown bus operation %c in the test file", opChar);
                end else begin
                    driveStart(opChar == "R", addrVal);
                    repeat (gapVal - 1) begin
                        @(negedge CLK40);
                        tsN = 1'b1;         // Bus idle in the gap
                    end
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        @(negedge CLK40);
        tsN = 1'b1;
        waitForAcks(expAcks);
        waitForIdle();
        @(posedge CLK40);
        checkCount("tack pulses", ackCount, expAcks);
        // Second reset on a quiet bus
        @(negedge CLK40);
        RESETn = 1'b0;
        repeat (4) @(negedge CLK40);
        RESETn = 1'b1;
        repeat (3) @(negedge CLK40);
        $display("Errors: %0d mismatch, %0d timeout, %0d other",
                 mismatchErrors, timeoutErrors, otherErrors);
        if (mismatchErrors + timeoutErrors + otherErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== bench/flashControllerTests.txt ====
# op (R or W), word address A[23:1] in hex, edges from this start to the next
# region 0xF is the flash window; gaps under 5 edges hit the hold-off
R 780000 6
W 7FFFFF 6
R 123456 6
W 000001 6
R 7A5A5A 6
W 7C3C3C 6
R 6FFFFF 6
R 7D0001 1
R 7D0002 1
R 7D0003 1
W 7D0004 1
R 7D0005 1
W 7D0006 6
R 7E0010 2
W 7E0020 2
R 7E0030 2
R 7E0040 6
W 7E1000 3
R 7E2000 3
W 7E3000 6
R 7F0000 4
W 7F1111 4
R 7F2222 6
W 7F3333 5
R 7F4444 5
W 7F5555 5
R 001234 1
R 7FFFFE 6
W 780001 6
R 780002 6

// ==== bench/flashController_assert.sv ====
`timescale 1ns/1ns
// Flash strobe checks
// Concurrent assertions on the cycle machine outputs, bound into flashCycleCtl

module flashControllerAssert (
    input logic CLK40,
    input logic RESETn,
    input logic tack,         // Transfer acknowledge
    input logic flashEnN,     // Chip enable
    input logic flashReadN,   // Output enable
    input logic flashWriteN   // Write enable
);

    // Acknowledge is one clock wide
    tackOnePulse: assert property (
        @(posedge CLK40) disable iff (!RESETn)
        tack |=> !tack
    ) else $error("tack stayed high for two cycles");

    // Never read and write at once
    strobesExclusive: assert property (
        @(posedge CLK40) disable iff (!RESETn)
        !(!flashReadN && !flashWriteN)
    ) else $error("flashReadN and flashWriteN low together");

    strobeInsideEnable: assert property (
        @(posedge CLK40) disable iff (!RESETn)
        (!flashReadN || !flashWriteN) |-> !flashEnN
    ) else $error("Flash strobe low while flashEnN is high");

endmodule

// Attach to every cycle machine instance
bind flashCycleCtl flashControllerAssert u_flashControllerAssert (
    .CLK40       (CLK40),
    .RESETn      (RESETn),
    .tack        (tack),
    .flashEnN    (flashEnN),
    .flashReadN  (flashReadN),
    .flashWriteN (flashWriteN)
);

// ==== flashController.f ====
source/flashPkg.sv
source/flashAddrDecode.sv
source/flashCycleCtl.sv
source/flashController.sv
bench/flashController_assert.sv
bench/flashControllerTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Builds the flash controller testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module flashControllerTb \
    -f flashController.f \
    -Mdir obj_dir -o simFlashController

./obj_dir/simFlashController +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation reported errors, see sim.log"
    exit 1
fi

echo "Simulation finished without errors"
exit 0

// ==== source/flashAddrDecode.sv ====
`timescale 1ns/1ns
// Flash address decoder
// Samples each bus start, checks the region field against the flash window
// and latches the word offset onto the flash address pins.
// Starts that land while a flash cycle is still running are dropped here.

module flashAddrDecode #(
    parameter logic [flashPkg::regionBits-1:0] flashRegion = flashPkg::flashRegionDefault
) (
    input  logic                  CLK40,
    input  logic                  RESETn,
    input  logic                  tsN,        // Transfer start, low active
    input  logic                  rnW,        // High for read
    input  flashPkg::busAddrT     addr,       // Word address A[23:1]
    output logic                  cycleReq,   // One-cycle start strobe
    output logic                  cycleWrite, // Direction of the request
    output flashPkg::flashOffsetT flashA      // Flash word address pins
);

    // A flash cycle blocks new starts on the four edges after its own
    localparam int holdEdges = 4;

    logic [2:0] holdCnt;  // Edges left in the hold-off window
    logic       inWindow; // Region field hits flash
    logic       accept;   // Flash start taken on this edge

    assign inWindow = (addr.fields.regionSel == flashRegion);
    assign accept   = !tsN && inWindow && (holdCnt == 3'd0);

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            cycleReq <= 1'b0;
            holdCnt  <= 3'd0;
        end else begin
            cycleReq <= accept;                 // High one cycle per taken start
            if (accept) begin
                holdCnt <= 3'(holdEdges);       // Open hold-off window
            end else if (holdCnt != 3'd0) begin
                holdCnt <= holdCnt - 3'd1;      // Count down to idle
            end
        end
    end

    // Direction and offset only move on a taken start,
    // so dropped or foreign starts leave the flash pins alone
    always_ff @(posedge CLK40) begin
        if (accept) begin
            cycleWrite <= !rnW;                     // Write when rnW low
            flashA     <= addr.fields.flashOffset;  // Offset field of the union
        end
    end

endmodule

// ==== source/flashController.sv ====
`timescale 1ns/1ns
// Flash controller top level
// Joins the address decoder and the cycle machine between the 68040-style
// local bus and the flash device, and passes reset on to the flash

module flashController #(
    parameter logic [flashPkg::regionBits-1:0] flashRegion = flashPkg::flashRegionDefault
) (
    input  logic                  CLK40,
    input  logic                  RESETn,
    // Bus side
    input  logic                  tsN,         // Transfer start
    input  logic                  rnW,         // Read, not write
    input  flashPkg::busAddrT     addr,        // A[23:1]
    output logic                  tack,        // Transfer acknowledge
    // Flash side
    output flashPkg::flashOffsetT flashA,      // Word address pins
    output logic                  flashEnN,    // Chip enable
    output logic                  flashReadN,  // Output enable
    output logic                  flashWriteN, // Write enable
    output logic                  flashRstN    // Flash reset
);

    logic cycleReq;   // Decoder start strobe
    logic cycleWrite; // Direction of that start

    assign flashRstN = RESETn;  // Flash resets with the board

    // Start sampling and window decode
    flashAddrDecode #(
        .flashRegion (flashRegion)
    ) u_flashAddrDecode (
        .CLK40      (CLK40),
        .RESETn     (RESETn),
        .tsN        (tsN),
        .rnW        (rnW),
        .addr       (addr),
        .cycleReq   (cycleReq),
        .cycleWrite (cycleWrite),
        .flashA     (flashA)
    );

    // Strobe and acknowledge sequencing
    flashCycleCtl u_flashCycleCtl (
        .CLK40       (CLK40),
        .RESETn      (RESETn),
        .cycleReq    (cycleReq),
        .cycleWrite  (cycleWrite),
        .tack        (tack),
        .flashEnN    (flashEnN),
        .flashReadN  (flashReadN),
        .flashWriteN (flashWriteN)
    );

endmodule

// ==== source/flashCycleCtl.sv ====
`timescale 1ns/1ns
// Flash cycle machine
// Five-state counter running one flash access per request with enable and
// read or write strobe, one transfer acknowledge pulse and early write release

module flashCycleCtl (
    input  logic CLK40,
    input  logic RESETn,
    input  logic cycleReq,    // Start strobe from the decoder
    input  logic cycleWrite,  // Direction, valid with cycleReq
    output logic tack,        // Transfer acknowledge to the bus
    output logic flashEnN,    // Flash chip enable
    output logic flashReadN,  // Flash output enable
    output logic flashWriteN  // Flash write enable
);

    // State codes advance one per clock once a cycle starts
    localparam logic [2:0] stIdle   = 3'd0; // Waiting for a request
    localparam logic [2:0] stAck    = 3'd1; // Raise acknowledge
    localparam logic [2:0] stWrRel  = 3'd2; // Drop acknowledge, end write strobe
    localparam logic [2:0] stEnRel  = 3'd3; // Release enable on writes
    localparam logic [2:0] stEnd    = 3'd4; // Finish reads, back to idle

    logic [2:0] state;       // Cycle counter
    logic       writeCycle;  // Direction of the running cycle

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            state       <= stIdle;
            tack        <= 1'b0;
            flashEnN    <= 1'b1;
            flashReadN  <= 1'b1;
            flashWriteN <= 1'b1;
            writeCycle  <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (cycleReq) begin
                        flashEnN    <= 1'b0;         // Select flash
                        flashReadN  <= cycleWrite;   // Read strobe with enable
                        flashWriteN <= !cycleWrite;  // Write strobe with enable
                        writeCycle  <= cycleWrite;   // Keep direction
                        state       <= stAck;
                    end
                end
                stAck: begin
                    tack  <= 1'b1;                  // Single acknowledge
                    state <= stWrRel;
                end
                stWrRel: begin
                    tack <= 1'b0;
                    if (writeCycle) begin
                        flashWriteN <= 1'b1;        // Write ends before enable
                    end
                    state <= stEnRel;
                end
                stEnRel: begin
                    if (writeCycle) begin
                        flashEnN <= 1'b1;           // Data held past strobe rise
                    end
                    state <= stEnd;
                end
                stEnd: begin
                    flashEnN    <= 1'b1;            // Read ends here
                    flashReadN  <= 1'b1;
                    flashWriteN <= 1'b1;
                    writeCycle  <= 1'b0;
                    state       <= stIdle;
                end
                default: begin
                    // Unused codes fall back to a quiet idle
                    tack        <= 1'b0;
                    flashEnN    <= 1'b1;
                    flashReadN  <= 1'b1;
                    flashWriteN <= 1'b1;
                    state       <= stIdle;
                end
            endcase
        end
    end

endmodule

// ==== source/flashPkg.sv ====
// Flash controller shared definitions
// Bus word address layout, flash window constants and field widths

package flashPkg;

    localparam int regionBits = 4;  // Window select width
    localparam int offsetBits = 19; // Flash word offset width
    localparam int addrBits   = regionBits + offsetBits; // A[23:1]

    // Region code of the flash window unless the top level overrides it
    localparam logic [regionBits-1:0] flashRegionDefault = 4'hF;

    // Flash address pin vector
    typedef logic [offsetBits-1:0] flashOffsetT;

    // Word address split into window select and flash offset
    typedef struct packed {
        logic [regionBits-1:0] regionSel;   // Upper bits, picks the region
        flashOffsetT           flashOffset; // Lower bits, word inside flash
    } busAddrFieldsT;

    // Same 23-bit word address seen whole or split
    typedef union packed {
        logic [addrBits-1:0] raw;    // Whole A[23:1]
        busAddrFieldsT       fields; // Region and offset view
    } busAddrT;

endpackage
